// ==== source/branchPkg.sv ====
`default_nettype none

package branchPkg;

    localparam int tagW = 4;

    typedef logic [31:0] dataT;
    typedef logic [31:0] addrT;
    typedef logic [31:0] instT;
    typedef logic [tagW-1:0] tagT;

    // operand value already present
    localparam tagT tagFree = '0;

    typedef enum logic [2:0] {
        opBeq,
        opBne,
        opBlt,
        opBge,
        opBltu,
        opBgeu,
        opJal,
        opJalr
    } branchOpT;

    typedef struct packed {
        instT inst;
        addrT pc;
        addrT predNext;
        dataT valO;
        tagT  tagO;
        dataT valT;
        tagT  destTag;
        tagT  robTag;
        // second operand tag
        tagT  tagT;
    } dispatchT;

    typedef struct packed {
        logic valid;
        tagT  tag;
        dataT data;
    } cdbT;

    typedef struct packed {
        branchOpT op;
        dataT     valO;
        tagT      tagO;
        dataT     valT;
        dataT     imm;
        addrT     pc;
        addrT     predNext;
        tagT      destTag;
        tagT      robTag;
        tagT      tagT;
    } stationEntryT;

    typedef struct packed {
        logic     valid;
        branchOpT op;
        dataT     valO;
        dataT     valT;
        dataT     imm;
        addrT     pc;
        addrT     predNext;
        tagT      destTag;
        tagT      robTag;
    } issueT;

    typedef struct packed {
        logic valid;
        addrT nextPc;
        dataT link;
        addrT predNext;
        logic isJump;
        tagT  destTag;
        tagT  robTag;
    } execT;

    typedef struct packed {
        logic valid;
        addrT target;
    } redirectT;

    typedef struct packed {
        logic valid;
        tagT  robTag;
    } doneT;

endpackage

`default_nettype wire

// ==== source/branchDecode.sv ====
`timescale 1ns/10ps
`default_nettype none

module branchDecode #(
    parameter int stationSize = 4
) (
    input  logic                     dispatchValid,
    input  branchPkg::dispatchT      dispatch,
    input  logic [stationSize-1:0]   freeSlots,
    output logic                     writeEn,
    output logic [stationSize-1:0]   writeSlot,
    output branchPkg::stationEntryT  entry
);

    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcJal    = 7'b1101111;
    localparam logic [6:0] opcJalr   = 7'b1100111;

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic               known;
    branchPkg::branchOpT op;
    branchPkg::dataT    immB;
    branchPkg::dataT    immJ;
    branchPkg::dataT    immI;
    branchPkg::dataT    imm;

    assign opcode = dispatch.inst[6:0];
    assign funct3 = dispatch.inst[14:12];

    assign immB = {{20{dispatch.inst[31]}}, dispatch.inst[7], dispatch.inst[30:25],
                   dispatch.inst[11:8], 1'b0};
    assign immJ = {{12{dispatch.inst[31]}}, dispatch.inst[19:12], dispatch.inst[20],
                   dispatch.inst[30:21], 1'b0};
    assign immI = {{21{dispatch.inst[31]}}, dispatch.inst[30:20]};

    always_comb begin
        known = 1'b0;
        op    = branchPkg::opBeq;
        case (opcode)
            opcBranch: begin
                known = 1'b1;
                case (funct3)
                    3'b000:  op = branchPkg::opBeq;
                    3'b001:  op = branchPkg::opBne;
                    3'b100:  op = branchPkg::opBlt;
                    3'b101:  op = branchPkg::opBge;
                    3'b110:  op = branchPkg::opBltu;
                    3'b111:  op = branchPkg::opBgeu;
                    // 010 and 011 are reserved
                    default: known = 1'b0;
                endcase
            end
            opcJal: begin
                known = 1'b1;
                op    = branchPkg::opJal;
            end
            opcJalr: begin
                known = (funct3 == 3'b000);
                op    = branchPkg::opJalr;
            end
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            branchPkg::opJal:  imm = immJ;
            branchPkg::opJalr: imm = immI;
            default:           imm = immB;
        endcase
    end

    // lowest free slot as one-hot
    assign writeSlot = freeSlots & (~freeSlots + stationSize'(1));
    assign writeEn   = dispatchValid && known && (|freeSlots);

    always_comb begin
        entry          = '0;
        entry.op       = op;
        entry.valO     = dispatch.valO;
        entry.tagO     = dispatch.tagO;
        entry.valT     = dispatch.valT;
        entry.tagT     = dispatch.tagT;
        entry.imm      = imm;
        entry.pc       = dispatch.pc;
        entry.predNext = dispatch.predNext;
        entry.destTag  = dispatch.destTag;
        entry.robTag   = dispatch.robTag;
    end

endmodule

`default_nettype wire

// ==== source/branchStation.sv ====
`timescale 1ns/10ps
`default_nettype none

module branchStation #(
    parameter int stationSize = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     writeEn,
    input  logic [stationSize-1:0]   writeSlot,
    input  branchPkg::stationEntryT  entry,
    input  branchPkg::cdbT           cdbIn,
    output logic [stationSize-1:0]   freeSlots,
    output branchPkg::issueT         issue
);

    branchPkg::stationEntryT slots [stationSize];
    branchPkg::stationEntryT woke  [stationSize];
    branchPkg::stationEntryT incoming;
    branchPkg::stationEntryT pickEntry;

    logic [stationSize-1:0] occupied;
    logic [stationSize-1:0] ready;
    logic [stationSize-1:0] pick;
    logic [stationSize-1:0] written;

    // apply one broadcast to an entry's waiting operands
    function automatic branchPkg::stationEntryT wakeup(
        input branchPkg::stationEntryT e,
        input branchPkg::cdbT          c
    );
        branchPkg::stationEntryT w;
        w = e;
        if (c.valid && c.tag != branchPkg::tagFree) begin
            if (e.tagO == c.tag) begin
                w.valO = c.data;
                w.tagO = branchPkg::tagFree;
            end
            if (e.tagT == c.tag) begin
                w.valT = c.data;
                w.tagT = branchPkg::tagFree;
            end
        end
        return w;
    endfunction

    // incoming entry sees the same broadcast as the stored ones
    assign incoming = wakeup(entry, cdbIn);

    always_comb begin
        for (int i = 0; i < stationSize; i++) begin
            woke[i]  = wakeup(slots[i], cdbIn);
            ready[i] = occupied[i]
                       && woke[i].tagO == branchPkg::tagFree
                       && woke[i].tagT == branchPkg::tagFree;
        end
    end

    // lowest ready index wins
    assign pick = ready & (~ready + stationSize'(1));

    always_comb begin
        pickEntry = '0;
        for (int i = 0; i < stationSize; i++) begin
            if (pick[i]) begin
                pickEntry = woke[i];
            end
        end
    end

    assign written   = writeEn ? writeSlot : '0;
    assign freeSlots = ~occupied;

    always_ff @(posedge clk) begin
        for (int i = 0; i < stationSize; i++) begin
            if (written[i]) begin
                slots[i] <= incoming;
            end else begin
                slots[i] <= woke[i];
            end
        end

        issue.op       <= pickEntry.op;
        issue.valO     <= pickEntry.valO;
        issue.valT     <= pickEntry.valT;
        issue.imm      <= pickEntry.imm;
        issue.pc       <= pickEntry.pc;
        issue.predNext <= pickEntry.predNext;
        issue.destTag  <= pickEntry.destTag;
        issue.robTag   <= pickEntry.robTag;

        if (reset) begin
            occupied    <= '0;
            issue.valid <= 1'b0;
        end else begin
            // issued slot frees at the same edge
            occupied    <= (occupied & ~pick) | written;
            issue.valid <= |ready;
        end
    end

endmodule

`default_nettype wire

// ==== source/branchExecute.sv ====
`timescale 1ns/10ps
`default_nettype none

module branchExecute (
    input  logic              clk,
    input  logic              reset,
    input  branchPkg::issueT  issue,
    output branchPkg::execT   exec
);

    logic            taken;
    logic            isJump;
    branchPkg::addrT target;
    branchPkg::addrT seqPc;
    branchPkg::addrT jumpBase;

    always_comb begin
        isJump = 1'b0;
        case (issue.op)
            branchPkg::opBeq:  taken = (issue.valO == issue.valT);
            branchPkg::opBne:  taken = (issue.valO != issue.valT);
            branchPkg::opBlt:  taken = ($signed(issue.valO) < $signed(issue.valT));
            branchPkg::opBge:  taken = ($signed(issue.valO) >= $signed(issue.valT));
            branchPkg::opBltu: taken = (issue.valO < issue.valT);
            branchPkg::opBgeu: taken = (issue.valO >= issue.valT);
            default: begin
                // jal, jalr
                taken  = 1'b1;
                isJump = 1'b1;
            end
        endcase
    end

    assign seqPc    = issue.pc + 32'd4;
    assign jumpBase = issue.valO + issue.imm;

    // jalr drops bit 0 of the sum
    assign target = (issue.op == branchPkg::opJalr) ? {jumpBase[31:1], 1'b0}
                                                    : issue.pc + issue.imm;

    always_ff @(posedge clk) begin
        exec.nextPc   <= taken ? target : seqPc;
        exec.link     <= seqPc;
        exec.predNext <= issue.predNext;
        exec.isJump   <= isJump;
        exec.destTag  <= issue.destTag;
        exec.robTag   <= issue.robTag;
        if (reset) begin
            exec.valid <= 1'b0;
        end else begin
            exec.valid <= issue.valid;
        end
    end

endmodule

`default_nettype wire

// ==== source/branchResult.sv ====
`timescale 1ns/10ps
`default_nettype none

module branchResult (
    input  logic                 clk,
    input  logic                 reset,
    input  branchPkg::execT      exec,
    output branchPkg::cdbT       cdbOut,
    output branchPkg::redirectT  redirect,
    output branchPkg::doneT      done
);

    logic mispredict;
    logic writesLink;

    assign mispredict = (exec.nextPc != exec.predNext);

    // only jumps with a real destination put the link on the bus
    assign writesLink = exec.isJump && (exec.destTag != branchPkg::tagFree);

    always_ff @(posedge clk) begin
        done.robTag     <= exec.robTag;
        redirect.target <= exec.nextPc;
        cdbOut.tag      <= exec.destTag;
        cdbOut.data     <= exec.link;
        if (reset) begin
            done.valid     <= 1'b0;
            redirect.valid <= 1'b0;
            cdbOut.valid   <= 1'b0;
        end else begin
            done.valid     <= exec.valid;
            redirect.valid <= exec.valid && mispredict;
            cdbOut.valid   <= exec.valid && writesLink;
        end
    end

endmodule

`default_nettype wire

// ==== source/branchUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module branchUnit #(
    parameter int stationSize = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispatchValid,
    input  branchPkg::dispatchT  dispatch,
    input  branchPkg::cdbT       cdbIn,
    output logic                 stationFull,
    output branchPkg::cdbT       cdbOut,
    output branchPkg::redirectT  redirect,
    output branchPkg::doneT      done
);

    logic [stationSize-1:0]  freeSlots;
    logic [stationSize-1:0]  writeSlot;
    logic                    writeEn;
    branchPkg::stationEntryT entry;
    branchPkg::issueT        issue;
    branchPkg::execT         exec;

    assign stationFull = ~|freeSlots;

    branchDecode #(
        .stationSize (stationSize)
    ) decode (
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .freeSlots     (freeSlots),
        .writeEn       (writeEn),
        .writeSlot     (writeSlot),
        .entry         (entry)
    );

    branchStation #(
        .stationSize (stationSize)
    ) station (
        .clk       (clk),
        .reset     (reset),
        .writeEn   (writeEn),
        .writeSlot (writeSlot),
        .entry     (entry),
        .cdbIn     (cdbIn),
        .freeSlots (freeSlots),
        .issue     (issue)
    );

    branchExecute execute (
        .clk   (clk),
        .reset (reset),
        .issue (issue),
        .exec  (exec)
    );

    branchResult result (
        .clk      (clk),
        .reset    (reset),
        .exec     (exec),
        .cdbOut   (cdbOut),
        .redirect (redirect),
        .done     (done)
    );

endmodule

`default_nettype wire

// ==== test/branchModel.svh ====
`ifndef BRANCH_MODEL_SVH
`define BRANCH_MODEL_SVH

// one dispatched instruction as the model sees it
typedef struct packed {
    logic                known;
    branchPkg::instT     inst;
    branchPkg::branchOpT op;
    branchPkg::dataT     imm;
    branchPkg::addrT     pc;
    branchPkg::addrT     predNext;
    branchPkg::dataT     valO;
    branchPkg::tagT      tagO;
    branchPkg::dataT     valT;
    branchPkg::tagT      tagT;
    branchPkg::tagT      destTag;
    branchPkg::tagT      robTag;
} modelEntryT;

// accepted and not yet completed
modelEntryT inFlight[$];

function automatic int findEntry(input branchPkg::tagT robTag);
    for (int i = 0; i < inFlight.size(); i++) begin
        if (inFlight[i].robTag == robTag) begin
            return i;
        end
    end
    return -1;
endfunction

// every waiting operand picks up the broadcast value
task automatic applyBroadcast(input branchPkg::tagT tag, input branchPkg::dataT data);
    foreach (inFlight[i]) begin
        if (inFlight[i].tagO == tag) begin
            inFlight[i].valO = data;
            inFlight[i].tagO = '0;
        end
        if (inFlight[i].tagT == tag) begin
            inFlight[i].valT = data;
            inFlight[i].tagT = '0;
        end
    end
endtask

// RV32I next-PC rules
function automatic branchPkg::addrT expectedNext(input modelEntryT m);
    logic            taken;
    branchPkg::addrT target;
    target = m.pc + m.imm;
    case (m.op)
        branchPkg::opBeq:  taken = (m.valO == m.valT);
        branchPkg::opBne:  taken = (m.valO != m.valT);
        branchPkg::opBlt:  taken = ($signed(m.valO) < $signed(m.valT));
        branchPkg::opBge:  taken = ($signed(m.valO) >= $signed(m.valT));
        branchPkg::opBltu: taken = (m.valO < m.valT);
        branchPkg::opBgeu: taken = (m.valO >= m.valT);
        branchPkg::opJalr: begin
            taken  = 1'b1;
            target = (m.valO + m.imm) & 32'hffff_fffe;
        end
        default:           taken = 1'b1;
    endcase
    return taken ? target : m.pc + 32'd4;
endfunction

// regs holds rd, rs1 and rs2 from low to high
function automatic branchPkg::instT encodeInst(input modelEntryT m, input logic [14:0] regs);
    logic [2:0] f3;
    case (m.op)
        branchPkg::opBne:  f3 = 3'b001;
        branchPkg::opBlt:  f3 = 3'b100;
        branchPkg::opBge:  f3 = 3'b101;
        branchPkg::opBltu: f3 = 3'b110;
        branchPkg::opBgeu: f3 = 3'b111;
        default:           f3 = 3'b000;
    endcase
    if (m.op == branchPkg::opJal) begin
        return {m.imm[20], m.imm[10:1], m.imm[11], m.imm[19:12], regs[4:0], 7'b1101111};
    end
    if (m.op == branchPkg::opJalr) begin
        return {m.imm[11:0], regs[9:5], 3'b000, regs[4:0], 7'b1100111};
    end
    return {m.imm[12], m.imm[10:5], regs[14:10], regs[9:5], f3, m.imm[4:1], m.imm[11],
            7'b1100011};
endfunction

`endif

// ==== test/branchUnitTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module branchUnitTb;

    localparam int stationSize  = 4;
    localparam int randomCycles = 600;
    // random slots plus the five directed dispatches
    localparam int plannedDispatches = randomCycles + 5;
    localparam int cycleLimit = 40 * plannedDispatches + 100;

    logic                clk;
    logic                reset;
    logic                dispatchValid;
    branchPkg::dispatchT dispatch;
    branchPkg::cdbT      cdbIn;
    logic                stationFull;
    branchPkg::cdbT      cdbOut;
    branchPkg::redirectT redirect;
    branchPkg::doneT     done;

    integer         seed;
    int             cycles = 0;
    logic [15:0]    waitingTags;
    branchPkg::tagT nextRob;
    string          phase;

    `include "branchModel.svh"

    branchUnit #(
        .stationSize (stationSize)
    ) uut (
        .clk           (clk),
        .reset         (reset),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .cdbIn         (cdbIn),
        .stationFull   (stationFull),
        .cdbOut        (cdbOut),
        .redirect      (redirect),
        .done          (done)
    );

    always #5 clk = ~clk;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (expected === actual)
        else failRun($sformatf("CHECK FAILED %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic pendingTag(output branchPkg::tagT tag);
        tag = '0;
        if (({$random(seed)} % 4) == 0) begin
            tag = branchPkg::tagT'(1 + {$random(seed)} % 14);
            waitingTags[tag] = 1'b1;
        end
    endtask

    // robTag not held by any entry in flight
    task automatic freeRobTag(output branchPkg::tagT tag);
        while (findEntry(nextRob) >= 0) begin
            nextRob++;
        end
        tag = nextRob;
        nextRob++;
    endtask

    task automatic randomEntry(output modelEntryT m);
        int          kind;
        logic [31:0] r;
        logic [31:0] regs;
        kind = {$random(seed)} % 9;
        r    = $random(seed);
        regs = $random(seed);
        m       = '0;
        // kind 8 stands for a non-branch opcode
        m.known = (kind < 8);
        m.op    = branchPkg::branchOpT'(kind[2:0]);
        case (m.op)
            branchPkg::opJal:  m.imm = {{12{r[19]}}, r[19:1], 1'b0};
            branchPkg::opJalr: m.imm = {{21{r[11]}}, r[10:0]};
            default:           m.imm = {{20{r[11]}}, r[11:1], 1'b0};
        endcase
        m.pc      = {$random(seed)} & 32'hffff_fffc;
        m.valO    = $random(seed);
        m.valT    = (({$random(seed)} % 4) == 0) ? m.valO : $random(seed);
        m.destTag = regs[3:0];
        freeRobTag(m.robTag);
        pendingTag(m.tagO);
        pendingTag(m.tagT);
        case ({$random(seed)} % 3)
            0:       m.predNext = m.pc + 32'd4;
            1:       m.predNext = m.pc + m.imm;
            default: m.predNext = (m.valO + m.imm) & 32'hffff_fffe;
        endcase
        m.inst = m.known ? encodeInst(m, regs[14:0]) : {regs[24:0], 7'b0110011};
    endtask

    task automatic chooseBroadcast(input logic eager, output branchPkg::tagT tag);
        int start;
        tag = '0;
        if (waitingTags != '0 && (eager || ({$random(seed)} % 3) == 0)) begin
            start = {$random(seed)} % 16;
            for (int k = 0; k < 16; k++) begin
                if (tag == '0 && waitingTags[(start + k) % 16]) begin
                    tag = branchPkg::tagT'((start + k) % 16);
                end
            end
            waitingTags[tag] = 1'b0;
        end
    endtask

    // one cycle of stimulus; btag of zero means no broadcast
    task automatic driveCycle(input logic want, input logic ignoreFull, input modelEntryT m,
                              input branchPkg::tagT btag);
        branchPkg::dataT bdata;
        logic            valid;
        bdata = $random(seed);
        @(posedge clk);
        #1;
        valid = want && (ignoreFull || !stationFull || ({$random(seed)} % 8) == 0);
        dispatchValid     = valid;
        dispatch.inst     = m.inst;
        dispatch.pc       = m.pc;
        dispatch.predNext = m.predNext;
        dispatch.valO     = m.valO;
        dispatch.tagO     = m.tagO;
        dispatch.valT     = m.valT;
        dispatch.tagT     = m.tagT;
        dispatch.destTag  = m.destTag;
        dispatch.robTag   = m.robTag;
        cdbIn.valid = (btag != '0);
        cdbIn.tag   = btag;
        cdbIn.data  = bdata;
        if (valid && m.known && !stationFull) begin
            inFlight.push_back(m);
        end
        // same-cycle broadcast also reaches the entry just written
        if (btag != '0) begin
            applyBroadcast(btag, bdata);
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            failRun($sformatf("timeout after %0d cycles, %0d instructions never completed",
                              cycles, inFlight.size()));
        end
    end

    // outputs checked at the falling edge
    always @(negedge clk) begin : monitor
        int              idx;
        modelEntryT      m;
        branchPkg::addrT expNext;
        logic            expRedirect;
        logic            expLink;
        if (!reset && done.valid) begin
            idx = findEntry(done.robTag);
            assert (idx >= 0)
            else failRun($sformatf("%s: done for robTag %0d, which is not in flight",
                                   phase, done.robTag));
            m = inFlight[idx];
            assert (m.tagO == '0 && m.tagT == '0)
            else failRun($sformatf("%s: robTag %0d completed before its operand broadcast",
                                   phase, m.robTag));
            expNext     = expectedNext(m);
            expRedirect = (expNext != m.predNext);
            expLink     = (m.op == branchPkg::opJal || m.op == branchPkg::opJalr)
                          && m.destTag != '0;
            checkValue($sformatf("%s %s redirect.valid", phase, m.op.name()),
                       expRedirect, redirect.valid);
            if (expRedirect) begin
                checkValue($sformatf("%s %s redirect.target", phase, m.op.name()),
                           expNext, redirect.target);
            end
            checkValue($sformatf("%s %s cdbOut.valid", phase, m.op.name()),
                       expLink, cdbOut.valid);
            if (expLink) begin
                checkValue($sformatf("%s %s cdbOut.tag", phase, m.op.name()),
                           m.destTag, cdbOut.tag);
                checkValue($sformatf("%s %s cdbOut.data", phase, m.op.name()),
                           m.pc + 32'd4, cdbOut.data);
            end
            inFlight.delete(idx);
        end else if (!reset) begin
            checkValue($sformatf("%s idle redirect.valid", phase), 0, redirect.valid);
            checkValue($sformatf("%s idle cdbOut.valid", phase), 0, cdbOut.valid);
        end
    end

    initial begin : stimulus
        modelEntryT     m;
        branchPkg::tagT btag;
        seed          = 32'h1447_ae31;
        clk           = 1'b0;
        reset         = 1'b1;
        dispatchValid = 1'b0;
        dispatch      = '0;
        cdbIn         = '0;
        waitingTags   = '0;
        nextRob       = '0;
        phase         = "reset";
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        m = '0;
        repeat (4) begin
            driveCycle(1'b0, 1'b0, m, '0);
            assert (!stationFull) else failRun("stationFull high with an empty station");
        end

        // four bne entries wait on tag 15 and fill the station
        phase = "full station";
        for (int k = 0; k < 5; k++) begin
            randomEntry(m);
            m.known = 1'b1;
            m.op    = branchPkg::opBne;
            m.imm   = 32'd16;
            m.tagO  = 4'd15;
            m.inst  = encodeInst(m, 15'd0);
            driveCycle(1'b1, 1'b1, m, '0);
        end
        assert (stationFull) else failRun("stationFull low with four waiting entries");
        driveCycle(1'b0, 1'b0, m, 4'd15);

        phase = "random";
        repeat (randomCycles) begin
            randomEntry(m);
            chooseBroadcast(1'b0, btag);
            driveCycle(({$random(seed)} % 4) != 0, 1'b0, m, btag);
        end

        phase = "drain";
        m = '0;
        while (inFlight.size() != 0 || waitingTags != '0) begin
            chooseBroadcast(1'b1, btag);
            driveCycle(1'b0, 1'b0, m, btag);
        end
        repeat (10) driveCycle(1'b0, 1'b0, m, '0);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+test
source/branchPkg.sv
source/branchDecode.sv
source/branchStation.sv
source/branchExecute.sv
source/branchResult.sv
source/branchUnit.sv
test/branchUnitTb.sv

// ==== Bender.yml ====
package:
  name: branch_unit

sources:
  - source/branchPkg.sv
  - source/branchDecode.sv
  - source/branchStation.sv
  - source/branchExecute.sv
  - source/branchResult.sv
  - source/branchUnit.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/branchUnitTb.sv
